// ==== common/mvmem_params.svh ====
`ifndef MVMEM_PARAMS_SVH
`define MVMEM_PARAMS_SVH

// word and bank geometry.
`define MV_WIDTH    16

`define MV_NUMVBNK  4
`define MV_BITVBNK  2

`define MV_NUMVROW  16
`define MV_BITVROW  4

// bank index sits above the row bits.
`define MV_BITADDR  6

`endif

// ==== common/mvmem_pkg.sv ====
`default_nettype none
`include "mvmem_params.svh"

package mvmem_pkg;

  typedef struct packed {
    logic                   vld;
    logic [`MV_BITADDR-1:0] addr;
    logic [`MV_WIDTH-1:0]   data;
  } wr_req_t;

  typedef struct packed {
    logic                   vld;
    logic [`MV_BITADDR-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic                 vld;
    logic [`MV_WIDTH-1:0] data;
  } rd_rsp_t;

  // one map word per row.
  typedef struct packed {
    logic                   vld;
    logic [`MV_BITVBNK-1:0] bank;
  } map_entry_t;

  typedef struct packed {
    logic                   vld;
    logic [`MV_BITVROW-1:0] row;
    logic [`MV_WIDTH-1:0]   data;
  } bank_wr_t;

  typedef struct packed {
    logic                   vld;
    logic [`MV_BITVBNK-1:0] bank; // owner of the cached word.
    logic [`MV_BITVROW-1:0] row;
    logic [`MV_WIDTH-1:0]   data;
  } cache_wr_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_INIT,
    ST_READY
  } init_state_t;

endpackage

`default_nettype wire

// ==== mvmem_core.f ====
+incdir+common
common/mvmem_pkg.sv
verilog/mem_bank.sv
verilog/init_fsm.sv
pivot/write_resolver.sv
pivot/read_merge.sv
verilog/mvmem_core.sv
tb/tb_mvmem_core.sv

// ==== pivot/read_merge.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mvmem_params.svh"

module read_merge (
  input  logic                  clk,
  input  logic                  rstvld,
  input  logic                  ready,
  input  mvmem_pkg::rd_req_t    rd,
  input  mvmem_pkg::map_entry_t map_rd,
  input  logic [`MV_WIDTH-1:0]  cache_rd,
  input  logic [`MV_WIDTH-1:0]  piv_rd [`MV_NUMVBNK],
  output mvmem_pkg::rd_rsp_t    rd_rsp
);

  logic                   rd_vld_q;
  logic [`MV_BITVBNK-1:0] rd_bank_q;
  logic                   cache_hit;

  always_ff @(posedge clk) begin
    if (rstvld) begin
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= rd.vld && ready; // no response before init is done.
    end
  end

  always_ff @(posedge clk) begin
    rd_bank_q <= rd.addr[`MV_BITADDR-1 -: `MV_BITVBNK];
  end

  // map and banks answer in the same cycle as the staged bank.
  assign cache_hit = map_rd.vld && (map_rd.bank == rd_bank_q);

  always_comb begin
    rd_rsp.vld = rd_vld_q;
    if (cache_hit) begin
      rd_rsp.data = cache_rd;
    end else begin
      rd_rsp.data = piv_rd[rd_bank_q];
    end
  end

endmodule

`default_nettype wire

// ==== pivot/write_resolver.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mvmem_params.svh"

module write_resolver (
  input  logic                  clk,
  input  logic                  rstvld,
  input  logic                  ready,
  input  mvmem_pkg::wr_req_t    wr_a,
  input  mvmem_pkg::wr_req_t    wr_b,
  input  mvmem_pkg::map_entry_t map_a,
  input  mvmem_pkg::map_entry_t map_b,
  input  logic [`MV_WIDTH-1:0]  cache_b,
  input  mvmem_pkg::bank_wr_t   init_clr,
  output mvmem_pkg::bank_wr_t   piv_wr_a [`MV_NUMVBNK],
  output mvmem_pkg::bank_wr_t   piv_wr_b [`MV_NUMVBNK],
  output mvmem_pkg::cache_wr_t  cache_wr,
  output mvmem_pkg::bank_wr_t   map_wr
);
  import mvmem_pkg::*;

  localparam int MAPW = $bits(map_entry_t);

  logic                   same_addr;
  logic                   a_vld;
  logic                   b_vld;
  logic [`MV_BITADDR-1:0] a_addr;
  logic [`MV_BITADDR-1:0] b_addr;
  logic [`MV_WIDTH-1:0]   a_data;
  logic [`MV_WIDTH-1:0]   b_data;
  logic [`MV_BITVBNK-1:0] a_bank;
  logic [`MV_BITVBNK-1:0] b_bank;
  logic [`MV_BITVROW-1:0] a_row;
  logic [`MV_BITVROW-1:0] b_row;

  // last map and cache write, for back-to-back writes.
  logic                   mbyp_vld;
  logic [`MV_BITVROW-1:0] mbyp_row;
  map_entry_t             mbyp_ent;
  logic                   cbyp_vld;
  logic [`MV_BITVROW-1:0] cbyp_row;
  logic [`MV_WIDTH-1:0]   cbyp_data;

  map_entry_t             map_a_eff;
  map_entry_t             map_b_eff;
  logic [`MV_WIDTH-1:0]   cache_b_eff;
  map_entry_t             map_new;

  logic                   a_to_cache;
  logic                   same_bank;
  logic                   b_to_cache;
  logic                   evict;
  logic                   b_inval;
  logic                   pa_vld;
  logic                   pb_vld;
  logic [`MV_BITVBNK-1:0] pb_bank;
  logic [`MV_WIDTH-1:0]   pb_data;

  assign same_addr = wr_a.vld && wr_b.vld && (wr_a.addr == wr_b.addr);

  always_ff @(posedge clk) begin
    if (rstvld) begin
      a_vld    <= 1'b0;
      b_vld    <= 1'b0;
      mbyp_vld <= 1'b0;
      cbyp_vld <= 1'b0;
    end else begin
      a_vld    <= wr_a.vld && ready && !same_addr; // port b wins.
      b_vld    <= wr_b.vld && ready;
      mbyp_vld <= map_wr.vld;
      cbyp_vld <= cache_wr.vld;
    end
  end

  always_ff @(posedge clk) begin
    a_addr    <= wr_a.addr;
    a_data    <= wr_a.data;
    b_addr    <= wr_b.addr;
    b_data    <= wr_b.data;
    mbyp_row  <= map_wr.row;
    mbyp_ent  <= map_wr.data[MAPW-1:0];
    cbyp_row  <= cache_wr.row;
    cbyp_data <= cache_wr.data;
  end

  assign a_bank = a_addr[`MV_BITADDR-1 -: `MV_BITVBNK];
  assign b_bank = b_addr[`MV_BITADDR-1 -: `MV_BITVBNK];
  assign a_row  = a_addr[`MV_BITVROW-1:0];
  assign b_row  = b_addr[`MV_BITVROW-1:0];

  always_comb begin
    map_a_eff   = (mbyp_vld && (mbyp_row == a_row)) ? mbyp_ent : map_a;
    map_b_eff   = (mbyp_vld && (mbyp_row == b_row)) ? mbyp_ent : map_b;
    cache_b_eff = (cbyp_vld && (cbyp_row == b_row)) ? cbyp_data : cache_b;

    a_to_cache = a_vld && map_a_eff.vld && (map_a_eff.bank == a_bank);
    same_bank  = a_vld && b_vld && (a_bank == b_bank);
    b_to_cache = !a_to_cache && same_bank;
    evict      = b_to_cache && map_b_eff.vld && (map_b_eff.bank != b_bank);
    b_inval    = !b_to_cache && b_vld && map_b_eff.vld && (map_b_eff.bank == b_bank);

    pa_vld  = a_vld && !a_to_cache;
    pb_vld  = b_to_cache ? evict : b_vld; // slot b carries the evicted word.
    pb_bank = b_to_cache ? map_b_eff.bank : b_bank;
    pb_data = b_to_cache ? cache_b_eff : b_data;
  end

  always_comb begin
    for (int i = 0; i < `MV_NUMVBNK; i++) begin
      piv_wr_a[i].vld  = pa_vld && (int'(a_bank) == i);
      piv_wr_a[i].row  = a_row;
      piv_wr_a[i].data = a_data;
      piv_wr_b[i].vld  = pb_vld && (int'(pb_bank) == i);
      piv_wr_b[i].row  = b_row;
      piv_wr_b[i].data = pb_data;
    end
  end

  always_comb begin
    cache_wr     = '0;
    map_wr       = '0;
    map_new.vld  = b_to_cache;
    map_new.bank = b_bank;
    if (init_clr.vld) begin
      cache_wr.vld  = 1'b1;
      cache_wr.row  = init_clr.row;
      cache_wr.data = init_clr.data;
      map_wr        = init_clr;
    end else begin
      if (a_to_cache) begin
        cache_wr = '{vld: 1'b1, bank: a_bank, row: a_row, data: a_data};
      end else if (b_to_cache) begin
        cache_wr = '{vld: 1'b1, bank: b_bank, row: b_row, data: b_data};
      end
      map_wr.vld             = b_to_cache || b_inval;
      map_wr.row             = b_row;
      map_wr.data[MAPW-1:0]  = map_new;
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_mvmem_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mvmem_params.svh"

module tb_mvmem_core;
  import mvmem_pkg::*;

  localparam int NADDR = 1 << `MV_BITADDR;

  // cycles per test, flush included.
  localparam int CYC_RST    = 16;
  localparam int CYC_INIT   = `MV_NUMVROW + 2 + 2;
  localparam int CYC_SINGLE = 8 * 4 + 2;
  localparam int CYC_BANK   = 2 * (16 + 2 + NADDR) + 2;
  localparam int CYC_SAME   = 4 * 4 + 2;
  localparam int CYC_RAND   = 4 * (12 + 2 + NADDR) + 2;
  localparam int CYC_LIMIT  =
    (CYC_RST + CYC_INIT + CYC_SINGLE + CYC_BANK + CYC_SAME + CYC_RAND) * 12 / 10;

  logic    clk;
  logic    rstvld;
  wr_req_t wr_a;
  wr_req_t wr_b;
  rd_req_t rd;
  rd_rsp_t rd_rsp;
  logic    ready;

  logic [`MV_WIDTH-1:0]   shadow [NADDR];
  logic                   written [NADDR];
  logic [15:0]            lfsr;
  logic                   ready_seen;
  logic                   cmp_en;
  rd_rsp_t                exp_next;
  rd_rsp_t                exp_cur;
  logic [`MV_BITADDR-1:0] exp_addr_next;
  logic [`MV_BITADDR-1:0] exp_addr_cur;
  int                     cyc = 0;
  int                     err_cnt = 0;
  int                     chk_cnt = 0;
  int                     test_cnt = 0;
  int                     test_fail = 0;
  int                     err_mark = 0;

  mvmem_core dut (
    .clk    (clk),
    .rstvld (rstvld),
    .wr_a   (wr_a),
    .wr_b   (wr_b),
    .rd     (rd),
    .rd_rsp (rd_rsp),
    .ready  (ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [`MV_WIDTH-1:0] ref_read(input logic [`MV_BITADDR-1:0] addr);
    return shadow[addr];
  endfunction

  function automatic wr_req_t mk_wr(input logic [`MV_BITADDR-1:0] addr,
                                    input logic [`MV_WIDTH-1:0]   data);
    wr_req_t w;
    w.vld  = 1'b1;
    w.addr = addr;
    w.data = data;
    return w;
  endfunction

  function automatic rd_req_t mk_rd(input logic [`MV_BITADDR-1:0] addr);
    rd_req_t r;
    r.vld  = 1'b1;
    r.addr = addr;
    return r;
  endfunction

  task automatic check_rsp(input rd_rsp_t exp, input rd_rsp_t act,
                           input logic [`MV_BITADDR-1:0] addr);
    chk_cnt++;
    if (act.vld !== exp.vld) begin
      err_cnt++;
      $display("ERR rd_rsp.vld addr %h: expected %h, got %h", addr, exp.vld, act.vld);
    end else if (exp.vld && (act.data !== exp.data)) begin
      err_cnt++;
      $display("ERR rd_rsp.data addr %h: expected %h, got %h", addr, exp.data, act.data);
    end
  endtask

  task automatic check_ready(input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("ERR ready: expected %h, got %h", exp, act);
    end
  endtask

  // one clock of stimulus, port b applied last so it wins.
  task automatic drive_cycle(input wr_req_t wa, input wr_req_t wb, input rd_req_t r);
    rd_rsp_t e;
    e.vld  = r.vld && ready_seen;
    e.data = ref_read(r.addr);
    @(posedge clk);
    wr_a          <= wa;
    wr_b          <= wb;
    rd            <= r;
    exp_next      <= e;
    exp_addr_next <= r.addr;
    if (wa.vld) begin
      shadow[wa.addr]  = wa.data;
      written[wa.addr] = 1'b1;
    end
    if (wb.vld) begin
      shadow[wb.addr]  = wb.data;
      written[wb.addr] = 1'b1;
    end
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) begin
      drive_cycle('0, '0, '0);
    end
  endtask

  task automatic read_written();
    for (int a = 0; a < NADDR; a++) begin
      if (written[a]) begin
        drive_cycle('0, '0, mk_rd(a[`MV_BITADDR-1:0]));
      end
    end
  endtask

  task automatic end_test(input string name);
    idle(2);
    test_cnt++;
    if (err_cnt == err_mark) begin
      $display("%s: pass", name);
    end else begin
      test_fail++;
      $display("%s: fail, %0d errors", name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  // response lands one cycle after its request.
  always @(negedge clk) begin
    if (cmp_en && (exp_cur.vld || (rd_rsp.vld !== 1'b0))) begin
      check_rsp(exp_cur, rd_rsp, exp_addr_cur);
    end
    exp_cur      = exp_next;
    exp_addr_cur = exp_addr_next;
  end

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc >= CYC_LIMIT) begin
      $display("timeout, run still busy after %0d cycles", cyc);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    logic [31:0]            rv;
    logic [31:0]            rd2;
    logic [`MV_BITADDR-1:0] addr;
    logic [`MV_BITVBNK-1:0] bank;
    wr_req_t                wa;
    wr_req_t                wb;
    rstvld        = 1'b1;
    wr_a          = '0;
    wr_b          = '0;
    rd            = '0;
    exp_next      = '0;
    exp_cur       = '0;
    exp_addr_next = '0;
    exp_addr_cur  = '0;
    ready_seen    = 1'b0;
    cmp_en        = 1'b0;
    lfsr          = 16'd44749;
    for (int a = 0; a < NADDR; a++) begin
      shadow[a]  = 'x;
      written[a] = 1'b0;
    end
    repeat (CYC_RST) @(posedge clk);
    rstvld <= 1'b0;
    cmp_en = 1'b1;

    for (int n = 0; n <= `MV_NUMVROW + 1; n++) begin
      if (n < `MV_NUMVROW) begin
        drive_cycle('0, '0, mk_rd(n[`MV_BITADDR-1:0])); // no response expected.
      end else begin
        idle(1);
      end
      @(negedge clk);
      check_ready(n == `MV_NUMVROW + 1, ready);
    end
    ready_seen = 1'b1;
    end_test("init sweep");

    for (int i = 0; i < 8; i++) begin
      rand_bits(`MV_BITADDR, rv);
      addr = rv[`MV_BITADDR-1:0];
      rand_bits(`MV_WIDTH, rv);
      if (i < 4) begin
        drive_cycle(mk_wr(addr, rv[`MV_WIDTH-1:0]), '0, '0);
      end else begin
        drive_cycle('0, mk_wr(addr, rv[`MV_WIDTH-1:0]), '0);
      end
      idle(2);
      drive_cycle('0, '0, mk_rd(addr));
    end
    end_test("single writes");

    // paired banks so the second write of a pair finds its row cached.
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < 16; i++) begin
        bank = (i / 2) % 4;
        rand_bits(`MV_WIDTH, rv);
        rand_bits(`MV_WIDTH, rd2);
        if (i % 2 == 0) begin
          wa = mk_wr({bank, 4'd3}, rv[`MV_WIDTH-1:0]);
          wb = mk_wr({bank, 4'd9}, rd2[`MV_WIDTH-1:0]);
        end else begin
          wa = mk_wr({bank, 4'd9}, rv[`MV_WIDTH-1:0]);
          wb = mk_wr({bank, 4'd3}, rd2[`MV_WIDTH-1:0]);
        end
        drive_cycle(wa, wb, '0);
      end
      idle(2);
      read_written();
    end
    end_test("same bank writes");

    for (int i = 0; i < 4; i++) begin
      rand_bits(`MV_BITADDR, rv);
      addr = rv[`MV_BITADDR-1:0];
      rand_bits(`MV_WIDTH, rv);
      rand_bits(`MV_WIDTH, rd2);
      drive_cycle(mk_wr(addr, rv[`MV_WIDTH-1:0]), mk_wr(addr, rd2[`MV_WIDTH-1:0]), '0);
      idle(2);
      drive_cycle('0, '0, mk_rd(addr));
    end
    end_test("same address writes");

    for (int burst = 0; burst < 4; burst++) begin
      for (int i = 0; i < 12; i++) begin
        rand_bits(`MV_BITADDR + `MV_WIDTH + 1, rv);
        wa     = mk_wr(rv[`MV_BITADDR+`MV_WIDTH-1 -: `MV_BITADDR], rv[`MV_WIDTH-1:0]);
        wa.vld = rv[`MV_BITADDR+`MV_WIDTH];
        rand_bits(`MV_BITADDR + `MV_WIDTH + 1, rv);
        wb     = mk_wr(rv[`MV_BITADDR+`MV_WIDTH-1 -: `MV_BITADDR], rv[`MV_WIDTH-1:0]);
        wb.vld = rv[`MV_BITADDR+`MV_WIDTH];
        drive_cycle(wa, wb, '0);
      end
      idle(2);
      read_written();
    end
    end_test("random bursts");

    $display("tests %0d, failing %0d, checks %0d, errors %0d",
             test_cnt, test_fail, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/init_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mvmem_params.svh"

module init_fsm (
  input  logic                clk,
  input  logic                rstvld,
  output logic                ready,
  output mvmem_pkg::bank_wr_t init_clr
);
  import mvmem_pkg::*;

  init_state_t            state;
  logic [`MV_BITVROW-1:0] row;
  logic                   last_row;

  assign last_row = (int'(row) == `MV_NUMVROW - 1);

  always_ff @(posedge clk) begin
    if (rstvld) begin
      state <= ST_IDLE;
      row   <= '0;
      ready <= 1'b0;
    end else begin
      ready <= (state == ST_READY); // one cycle after the sweep ends.
      case (state)
        ST_IDLE: begin
          state <= ST_INIT;
          row   <= '0;
        end
        ST_INIT: begin
          row <= row + 1'b1;
          if (last_row) begin
            state <= ST_READY;
          end
        end
        default: begin
          state <= ST_READY;
        end
      endcase
    end
  end

  // zero data clears both map and cache rows.
  always_comb begin
    init_clr     = '0;
    init_clr.vld = (state == ST_INIT);
    init_clr.row = row;
  end

endmodule

`default_nettype wire

// ==== verilog/mem_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_bank #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 16
) (
  input  logic                     clk,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_row,
  input  logic [WIDTH-1:0]         wr_data,
  input  logic [$clog2(DEPTH)-1:0] rd_row,
  output logic [WIDTH-1:0]         rd_data
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_row] <= wr_data;
    end
  end

  // one cycle read, old word on a same-row write.
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_row];
  end

endmodule

`default_nettype wire

// ==== verilog/mvmem_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mvmem_params.svh"

module mvmem_core (
  input  logic               clk,
  input  logic               rstvld,
  input  mvmem_pkg::wr_req_t wr_a,
  input  mvmem_pkg::wr_req_t wr_b,
  input  mvmem_pkg::rd_req_t rd,
  output mvmem_pkg::rd_rsp_t rd_rsp,
  output logic               ready
);
  import mvmem_pkg::*;

  localparam int MAPW     = $bits(map_entry_t);
  localparam int NUMMAP   = 3; // read, write a, write b.
  localparam int NUMCACHE = 2; // read, write b.

  bank_wr_t               init_clr;
  bank_wr_t               piv_wr_a [`MV_NUMVBNK];
  bank_wr_t               piv_wr_b [`MV_NUMVBNK];
  bank_wr_t               map_wr;
  cache_wr_t              cache_wr;

  logic [`MV_BITVROW-1:0] rd_row;
  logic [`MV_BITVROW-1:0] wa_row;
  logic [`MV_BITVROW-1:0] wb_row;

  logic [`MV_BITVROW-1:0] map_row [NUMMAP];
  logic [MAPW-1:0]        map_q [NUMMAP];
  logic [`MV_BITVROW-1:0] cache_row [NUMCACHE];
  logic [`MV_WIDTH-1:0]   cache_q [NUMCACHE];
  logic [`MV_WIDTH-1:0]   piv_rd [`MV_NUMVBNK];

  map_entry_t             map_rd;
  map_entry_t             map_a;
  map_entry_t             map_b;

  assign rd_row = rd.addr[`MV_BITVROW-1:0];
  assign wa_row = wr_a.addr[`MV_BITVROW-1:0];
  assign wb_row = wr_b.addr[`MV_BITVROW-1:0];

  assign map_row[0]   = rd_row;
  assign map_row[1]   = wa_row;
  assign map_row[2]   = wb_row;
  assign cache_row[0] = rd_row;
  assign cache_row[1] = wb_row;

  assign map_rd = map_q[0];
  assign map_a  = map_q[1];
  assign map_b  = map_q[2];

  init_fsm u_init (
    .clk      (clk),
    .rstvld   (rstvld),
    .ready    (ready),
    .init_clr (init_clr)
  );

  write_resolver u_wres (
    .clk      (clk),
    .rstvld   (rstvld),
    .ready    (ready),
    .wr_a     (wr_a),
    .wr_b     (wr_b),
    .map_a    (map_a),
    .map_b    (map_b),
    .cache_b  (cache_q[1]),
    .init_clr (init_clr),
    .piv_wr_a (piv_wr_a),
    .piv_wr_b (piv_wr_b),
    .cache_wr (cache_wr),
    .map_wr   (map_wr)
  );

  read_merge u_rmrg (
    .clk      (clk),
    .rstvld   (rstvld),
    .ready    (ready),
    .rd       (rd),
    .map_rd   (map_rd),
    .cache_rd (cache_q[0]),
    .piv_rd   (piv_rd),
    .rd_rsp   (rd_rsp)
  );

  // at most one of the two slots targets a given bank.
  for (genvar i = 0; i < `MV_NUMVBNK; i++) begin : g_piv
    logic                   wr_en;
    logic [`MV_BITVROW-1:0] wr_row;
    logic [`MV_WIDTH-1:0]   wr_data;

    assign wr_en   = piv_wr_a[i].vld || piv_wr_b[i].vld;
    assign wr_row  = piv_wr_a[i].vld ? piv_wr_a[i].row : piv_wr_b[i].row;
    assign wr_data = piv_wr_a[i].vld ? piv_wr_a[i].data : piv_wr_b[i].data;

    mem_bank #(.DEPTH(`MV_NUMVROW), .WIDTH(`MV_WIDTH)) u_bank (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_row  (wr_row),
      .wr_data (wr_data),
      .rd_row  (rd_row),
      .rd_data (piv_rd[i])
    );
  end

  for (genvar i = 0; i < NUMCACHE; i++) begin : g_cache
    mem_bank #(.DEPTH(`MV_NUMVROW), .WIDTH(`MV_WIDTH)) u_bank (
      .clk     (clk),
      .wr_en   (cache_wr.vld),
      .wr_row  (cache_wr.row),
      .wr_data (cache_wr.data),
      .rd_row  (cache_row[i]),
      .rd_data (cache_q[i])
    );
  end

  for (genvar i = 0; i < NUMMAP; i++) begin : g_map
    mem_bank #(.DEPTH(`MV_NUMVROW), .WIDTH(MAPW)) u_bank (
      .clk     (clk),
      .wr_en   (map_wr.vld),
      .wr_row  (map_wr.row),
      .wr_data (map_wr.data[MAPW-1:0]),
      .rd_row  (map_row[i]),
      .rd_data (map_q[i])
    );
  end

endmodule

`default_nettype wire
